//--- build.f
rtl/spiPkg.sv
rtl/regPkg.sv
rtl/spiPinSync.sv
rtl/spiFrameDecoder.sv
rtl/regBank.sv
rtl/misoShifter.sv
rtl/flashBridge.sv
rtl/spiSlavePort.sv
tests/spiSlavePortTb.sv

//--- run.sh
#!/usr/bin/env bash
# Verilator build and run of the SPI slave port testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f build.f --top-module spiSlavePortTb --Mdir obj_dir -o simv \
	&& ./obj_dir/simv | tee /dev/stderr | grep "All checks passed" > /dev/null \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

//--- tests/spiSlavePortTb.sv
// Testbench for the SPI slave port with SPI master task, flash echo model, directed tests and timeout
`timescale 1ns/100ps
`default_nettype none

module spiSlavePortTb;

	// Whole run is about 25 frames of roughly 480 cycles
	localparam int TimeoutCycles = 20000;
	localparam int FrameBits = 56;

	logic iSCLK;
	logic rst;
	spiPkg::spiPins_t cpuPins;
	logic cpuMiso;
	logic spiThru;
	logic [spiPkg::FlashCount-1:0] deviceSel;
	spiPkg::flashBus_t fpgaBus;
	logic [spiPkg::FlashCount-1:0] fpgaMiso;
	spiPkg::flashBus_t flashBus;
	logic [spiPkg::FlashCount-1:0] flashMiso;
	regPkg::wrEvent_t wrEvent;

	integer seed;
	int cycleCount = 0;
	int errorCount = 0;
	int testCount = 0;
	int failedTests = 0;
	// Write event monitor
	int wrCount = 0;
	logic [15:0] lastWrAddr;
	logic [31:0] lastWrData;
	// Register contents as the map rules predict them
	logic [31:0] expRegs [regPkg::RegCount];

	spiSlavePort spiSlavePort_i (
		.iSCLK(iSCLK), .rst(rst),
		.cpuPins(cpuPins), .cpuMiso(cpuMiso),
		.spiThru(spiThru), .deviceSel(deviceSel),
		.fpgaBus(fpgaBus), .fpgaMiso(fpgaMiso),
		.flashBus(flashBus), .flashMiso(flashMiso),
		.wrEvent(wrEvent)
	);

	// Each flash echoes its MOSI
	assign flashMiso = flashBus.mosi;

	always #20 iSCLK = ~iSCLK;

	// Watchdog on total run length
	always @(posedge iSCLK)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TimeoutCycles)
		begin
			$display("Timeout: run stopped after %0d cycles without finishing", cycleCount);
			$display("Checks failed");
			$finish;
		end
	end

	// Count every cycle with wrEvent.valid high
	always @(negedge iSCLK)
	begin
		if (!rst && wrEvent.valid)
		begin
			wrCount <= wrCount + 1;
			lastWrAddr <= wrEvent.addr;
			lastWrData <= wrEvent.data;
		end
	end

	task automatic reportMismatch(input string testName, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		$display("FAIL %s (%s): expected 0x%h, actual 0x%h", testName, what, expected, actual);
		errorCount++;
	endtask

	task automatic closeTest(input string testName, input int errorsAtStart);
		testCount++;
		if (errorCount == errorsAtStart)
			$display("Test %s finished: ok", testName);
		else
		begin
			$display("Test %s finished: %0d errors", testName, errorCount - errorsAtStart);
			failedTests++;
		end
	endtask

	// Mode 0 master, SCK half period of 4 clocks, MSB first
	task automatic spiFrame(input int nBits, input logic [FrameBits-1:0] frame,
		output logic [31:0] rxWord);
		rxWord = '0;
		@(posedge iSCLK);
		cpuPins.cs <= 1'b0;
		cpuPins.sck <= 1'b0;
		cpuPins.mosi <= 1'b0;
		repeat (4) @(posedge iSCLK);
		for (int i = 0; i < nBits; i++)
		begin
			@(posedge iSCLK);
			cpuPins.sck <= 1'b0;
			cpuPins.mosi <= frame[FrameBits-1-i];
			repeat (4) @(posedge iSCLK);
			cpuPins.sck <= 1'b1;
			// MISO read just after the rise, data field only
			@(posedge iSCLK);
			@(negedge iSCLK);
			if (i >= spiPkg::CmdBits + spiPkg::AddrBits)
				rxWord = {rxWord[30:0], cpuMiso};
			repeat (2) @(posedge iSCLK);
		end
		@(posedge iSCLK);
		cpuPins.sck <= 1'b0;
		cpuPins.mosi <= 1'b0;
		repeat (4) @(posedge iSCLK);
		cpuPins.cs <= 1'b1;
		// Room for CS end and a late write event
		repeat (8) @(posedge iSCLK);
	endtask

	task automatic writeRegister(input logic [15:0] addr, input logic [31:0] data);
		logic [31:0] ignored;
		spiFrame(FrameBits, {spiPkg::CmdWrite, addr, data}, ignored);
	endtask

	task automatic readRegister(input logic [15:0] addr, output logic [31:0] data);
		spiFrame(FrameBits, {spiPkg::CmdRead, addr, 32'h0}, data);
	endtask

	// Test 1
	task automatic resetDefaults();
		string name;
		int errorsAtStart;
		logic [31:0] rx;
		name = "resetDefaults";
		errorsAtStart = errorCount;
		// CS outputs carry the idle master CS straight out of reset
		@(negedge iSCLK);
		if (flashBus.cs !== fpgaBus.cs)
			reportMismatch(name, "flashBus.cs idle", {29'd0, fpgaBus.cs}, {29'd0, flashBus.cs});
		for (int p = 0; p < 8; p++)
		begin
			@(posedge iSCLK);
			fpgaBus.cs <= 3'(p);
			@(posedge iSCLK);
			@(negedge iSCLK);
			if (flashBus.cs !== 3'(p))
				reportMismatch(name, "flashBus.cs", 32'(p), {29'd0, flashBus.cs});
		end
		@(posedge iSCLK);
		fpgaBus.cs <= '1;
		readRegister(16'h0000, rx);
		if (rx !== regPkg::DeviceId)
			reportMismatch(name, "read addr 0", regPkg::DeviceId, rx);
		if (wrCount != 0)
			reportMismatch(name, "wrEvent pulses", 32'd0, 32'(wrCount));
		closeTest(name, errorsAtStart);
	endtask

	// Test 2
	task automatic writeReadBack();
		string name;
		int errorsAtStart;
		int wrBefore;
		logic [31:0] value;
		logic [31:0] rx;
		name = "writeReadBack";
		errorsAtStart = errorCount;
		for (int a = 1; a < regPkg::RegCount; a++)
		begin
			value = $random(seed);
			// A changed value is needed for a write event
			if (value == expRegs[a])
				value = ~value;
			wrBefore = wrCount;
			writeRegister(16'(a), value);
			expRegs[a] = value;
			if (wrCount - wrBefore != 1)
				reportMismatch(name, "wrEvent pulses", 32'd1, 32'(wrCount - wrBefore));
			if (lastWrAddr !== 16'(a))
				reportMismatch(name, "wrEvent addr", 32'(a), {16'd0, lastWrAddr});
			if (lastWrData !== value)
				reportMismatch(name, "wrEvent data", value, lastWrData);
		end
		for (int a = 1; a < regPkg::RegCount; a++)
		begin
			readRegister(16'(a), rx);
			if (rx !== expRegs[a])
				reportMismatch(name, $sformatf("read addr %0d", a), expRegs[a], rx);
		end
		closeTest(name, errorsAtStart);
	endtask

	// Test 3
	task automatic mapEdgeCases();
		string name;
		int errorsAtStart;
		int wrBefore;
		logic [31:0] rx;
		logic [31:0] ignored;
		name = "mapEdgeCases";
		errorsAtStart = errorCount;
		wrBefore = wrCount;
		writeRegister(16'h0000, $random(seed));
		readRegister(16'h0000, rx);
		if (rx !== regPkg::DeviceId)
			reportMismatch(name, "read addr 0 after write", regPkg::DeviceId, rx);
		readRegister(16'h0009, rx);
		if (rx !== regPkg::UnmappedRead)
			reportMismatch(name, "read addr 9", regPkg::UnmappedRead, rx);
		// Unknown opcode carrying a write-shaped body
		spiFrame(FrameBits, {8'h05, 16'h0003, 32'h1234_5678}, ignored);
		if (wrCount != wrBefore)
			reportMismatch(name, "wrEvent pulses", 32'd0, 32'(wrCount - wrBefore));
		readRegister(16'h0003, rx);
		if (rx !== expRegs[3])
			reportMismatch(name, "read addr 3 after bad opcode", expRegs[3], rx);
		closeTest(name, errorsAtStart);
	endtask

	// Test 4
	task automatic abortedWrite();
		string name;
		int errorsAtStart;
		int wrBefore;
		logic [31:0] rx;
		logic [31:0] ignored;
		name = "abortedWrite";
		errorsAtStart = errorCount;
		wrBefore = wrCount;
		// CS rises partway through the address
		spiFrame(20, {spiPkg::CmdWrite, 16'h0004, ~expRegs[4]}, ignored);
		if (wrCount != wrBefore)
			reportMismatch(name, "wrEvent pulses", 32'd0, 32'(wrCount - wrBefore));
		readRegister(16'h0004, rx);
		if (rx !== expRegs[4])
			reportMismatch(name, "read addr 4", expRegs[4], rx);
		closeTest(name, errorsAtStart);
	endtask

	// Test 5
	task automatic thruSelectedFlash();
		string name;
		int errorsAtStart;
		int wrBefore;
		logic [31:0] r;
		logic [31:0] rx;
		logic prevMosi;
		spiPkg::spiPins_t pinsNow;
		spiPkg::flashBus_t busNow;
		spiPkg::flashBus_t expBus;
		name = "thruSelectedFlash";
		errorsAtStart = errorCount;
		@(posedge iSCLK);
		spiThru <= 1'b1;
		deviceSel <= 3'b010;
		repeat (4) @(posedge iSCLK);
		prevMosi = cpuPins.mosi;
		for (int n = 0; n < 8; n++)
		begin
			r = $random(seed);
			pinsNow = spiPkg::spiPins_t'(r[2:0]);
			busNow = spiPkg::flashBus_t'(r[11:3]);
			@(posedge iSCLK);
			cpuPins <= pinsNow;
			fpgaBus <= busNow;
			// Flash 1 from the CPU, the rest from the internal master
			expBus = busNow;
			expBus.sck[1] = pinsNow.sck;
			expBus.mosi[1] = pinsNow.mosi;
			expBus.cs[1] = pinsNow.cs;
			@(posedge iSCLK);
			@(negedge iSCLK);
			if (flashBus !== expBus)
				reportMismatch(name, "flashBus", {23'd0, expBus}, {23'd0, flashBus});
			// Echo still one stage behind here
			if (cpuMiso !== prevMosi)
				reportMismatch(name, "cpuMiso after 1 cycle", {31'd0, prevMosi}, {31'd0, cpuMiso});
			@(posedge iSCLK);
			@(negedge iSCLK);
			if (cpuMiso !== pinsNow.mosi)
				reportMismatch(name, "cpuMiso after 2 cycles", {31'd0, pinsNow.mosi},
					{31'd0, cpuMiso});
			prevMosi = pinsNow.mosi;
		end
		@(posedge iSCLK);
		cpuPins <= '{sck: 1'b0, mosi: 1'b0, cs: 1'b1};
		fpgaBus <= '{sck: '0, mosi: '0, cs: '1};
		repeat (4) @(posedge iSCLK);
		// A register write while bridged goes to the flash only
		wrBefore = wrCount;
		writeRegister(16'h0002, ~expRegs[2]);
		if (wrCount != wrBefore)
			reportMismatch(name, "wrEvent pulses", 32'd0, 32'(wrCount - wrBefore));
		@(posedge iSCLK);
		spiThru <= 1'b0;
		deviceSel <= '0;
		repeat (4) @(posedge iSCLK);
		readRegister(16'h0002, rx);
		if (rx !== expRegs[2])
			reportMismatch(name, "read addr 2", expRegs[2], rx);
		closeTest(name, errorsAtStart);
	endtask

	// Test 6
	task automatic thruNoFlash();
		string name;
		int errorsAtStart;
		logic [31:0] r;
		spiPkg::flashBus_t busNow;
		name = "thruNoFlash";
		errorsAtStart = errorCount;
		@(posedge iSCLK);
		spiThru <= 1'b1;
		deviceSel <= '0;
		repeat (4) @(posedge iSCLK);
		for (int n = 0; n < 6; n++)
		begin
			r = $random(seed);
			busNow = spiPkg::flashBus_t'(r[8:0]);
			@(posedge iSCLK);
			fpgaBus <= busNow;
			// Bridge stage then MISO stage
			repeat (2) @(posedge iSCLK);
			@(negedge iSCLK);
			if (cpuMiso !== 1'b1)
				reportMismatch(name, "cpuMiso", 32'd1, {31'd0, cpuMiso});
			if (fpgaMiso !== busNow.mosi)
				reportMismatch(name, "fpgaMiso", {29'd0, busNow.mosi}, {29'd0, fpgaMiso});
		end
		@(posedge iSCLK);
		spiThru <= 1'b0;
		fpgaBus <= '{sck: '0, mosi: '0, cs: '1};
		repeat (4) @(posedge iSCLK);
		closeTest(name, errorsAtStart);
	endtask

	initial
	begin
		iSCLK = 1'b0;
		rst = 1'b1;
		seed = 32'h33d4012b;
		cpuPins = '{sck: 1'b0, mosi: 1'b0, cs: 1'b1};
		spiThru = 1'b0;
		deviceSel = '0;
		fpgaBus = '{sck: '0, mosi: '0, cs: '1};
		for (int a = 0; a < regPkg::RegCount; a++)
			expRegs[a] = '0;
		repeat (2) @(posedge iSCLK);
		rst <= 1'b0;
		repeat (2) @(posedge iSCLK);
		resetDefaults();
		writeReadBack();
		mapEdgeCases();
		abortedWrite();
		thruSelectedFlash();
		thruNoFlash();
		$display("Summary: %0d tests, %0d failed, %0d errors", testCount, failedTests, errorCount);
		if (errorCount == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- rtl/spiSlavePort.sv
// SPI slave port top joining pin sync, frame decoder, register bank, MISO shifter and bridge
`timescale 1ns/100ps
`default_nettype none

module spiSlavePort (
	input wire iSCLK,
	input wire rst,
	// CPU pins
	input wire spiPkg::spiPins_t cpuPins,
	output logic cpuMiso,
	// Thru mode and flash choice
	input wire spiThru,
	input wire [spiPkg::FlashCount-1:0] deviceSel,
	// Internal flash master
	input wire spiPkg::flashBus_t fpgaBus,
	output logic [spiPkg::FlashCount-1:0] fpgaMiso,
	// External flash devices
	output spiPkg::flashBus_t flashBus,
	input wire [spiPkg::FlashCount-1:0] flashMiso,
	// Write notices to the fabric
	output regPkg::wrEvent_t wrEvent
);

	logic sckRise;
	logic sckFall;
	logic mosiBit;
	logic csActive;
	logic csStart;
	logic csEnd;
	regPkg::regCmd_t cmd;
	logic cmdValid;
	logic cmdReady;
	regPkg::regResp_t resp;
	logic respValid;
	logic respReady;
	logic shiftMiso;
	logic thruMiso;
	logic thruActive;

	spiPinSync spiPinSync_i (
		.iSCLK(iSCLK), .rst(rst), .pins(cpuPins),
		.sckRise(sckRise), .sckFall(sckFall), .mosiBit(mosiBit),
		.csActive(csActive), .csStart(csStart), .csEnd(csEnd)
	);

	// Decoder sits out frames meant for a flash
	spiFrameDecoder spiFrameDecoder_i (
		.iSCLK(iSCLK), .rst(rst), .decodeDisable(thruActive),
		.sckRise(sckRise), .mosiBit(mosiBit), .csActive(csActive), .csStart(csStart),
		.cmd(cmd), .cmdValid(cmdValid), .cmdReady(cmdReady)
	);

	regBank regBank_i (
		.iSCLK(iSCLK), .rst(rst),
		.cmd(cmd), .cmdValid(cmdValid), .cmdReady(cmdReady),
		.resp(resp), .respValid(respValid), .respReady(respReady),
		.wrEvent(wrEvent)
	);

	misoShifter misoShifter_i (
		.iSCLK(iSCLK), .rst(rst),
		.sckFall(sckFall), .csActive(csActive), .csEnd(csEnd),
		.resp(resp), .respValid(respValid), .respReady(respReady),
		.miso(shiftMiso)
	);

	flashBridge flashBridge_i (
		.iSCLK(iSCLK), .rst(rst), .cpuPins(cpuPins),
		.spiThru(spiThru), .deviceSel(deviceSel),
		.fpgaBus(fpgaBus), .flashMiso(flashMiso), .flashBus(flashBus),
		.fpgaMiso(fpgaMiso), .thruMiso(thruMiso), .thruActive(thruActive)
	);

	// Flash answers in thru mode, register data otherwise
	assign cpuMiso = thruActive ? thruMiso : shiftMiso;

endmodule

`default_nettype wire

//--- rtl/flashBridge.sv
// Registered pin mux from CPU or internal master to each flash and MISO return select
`timescale 1ns/100ps
`default_nettype none

module flashBridge (
	input wire iSCLK,
	input wire rst,
	input wire spiPkg::spiPins_t cpuPins,
	input wire spiThru,
	input wire [spiPkg::FlashCount-1:0] deviceSel,
	input wire spiPkg::flashBus_t fpgaBus,
	input wire [spiPkg::FlashCount-1:0] flashMiso,
	output spiPkg::flashBus_t flashBus,
	output logic [spiPkg::FlashCount-1:0] fpgaMiso,
	output logic thruMiso,
	output logic thruActive
);

	logic thruReg;
	logic misoPick;

	// Thru flag sampled once for the bridge and the decoder
	always_ff @(posedge iSCLK)
	begin
		if (rst)
			thruReg <= 1'b0;
		else
			thruReg <= spiThru;
	end

	assign thruActive = thruReg;

	// Lowest selected flash wins, idle MISO high otherwise
	always_comb
	begin
		misoPick = 1'b1;
		for (int i = spiPkg::FlashCount - 1; i >= 0; i--)
		begin
			if (deviceSel[i])
				misoPick = flashMiso[i];
		end
	end

	// Per-flash source select, internal master by default
	always_ff @(posedge iSCLK)
	begin
		for (int i = 0; i < spiPkg::FlashCount; i++)
		begin
			if (thruReg && deviceSel[i])
			begin
				flashBus.sck[i] <= cpuPins.sck;
				flashBus.mosi[i] <= cpuPins.mosi;
				flashBus.cs[i] <= cpuPins.cs;
			end
			else
			begin
				flashBus.sck[i] <= fpgaBus.sck[i];
				flashBus.mosi[i] <= fpgaBus.mosi[i];
				flashBus.cs[i] <= fpgaBus.cs[i];
			end
		end
		fpgaMiso <= flashMiso;
		thruMiso <= misoPick;
	end

endmodule

`default_nettype wire

//--- rtl/misoShifter.sv
// MISO shift register loading read responses and shifting MSB first on SCK fall
`timescale 1ns/100ps
`default_nettype none

module misoShifter (
	input wire iSCLK,
	input wire rst,
	input wire sckFall,
	input wire csActive,
	input wire csEnd,
	input wire regPkg::regResp_t resp,
	input wire respValid,
	output logic respReady,
	output logic miso
);

	regPkg::regData_t shiftReg;
	logic loaded;
	// First SCK fall after load belongs to the last address bit
	logic firstFall;

	// Also ready outside a frame so a late response drains
	assign respReady = !loaded;
	assign miso = loaded && shiftReg[$bits(regPkg::regData_t)-1];

	always_ff @(posedge iSCLK)
	begin
		if (rst)
		begin
			loaded <= 1'b0;
			firstFall <= 1'b0;
		end
		else if (csEnd)
			loaded <= 1'b0;
		else if (respValid && respReady)
		begin
			shiftReg <= resp.data;
			// Word taken with CS high is dropped
			loaded <= csActive;
			firstFall <= 1'b1;
		end
		else if (loaded && sckFall)
		begin
			// MSB stays out through the first fall
			if (firstFall)
				firstFall <= 1'b0;
			else
				shiftReg <= {shiftReg[$bits(regPkg::regData_t)-2:0], 1'b0};
		end
	end

endmodule

`default_nettype wire

//--- rtl/regBank.sv
// Register bank with device ID, write events and read responses
`timescale 1ns/100ps
`default_nettype none

module regBank (
	input wire iSCLK,
	input wire rst,
	input wire regPkg::regCmd_t cmd,
	input wire cmdValid,
	output logic cmdReady,
	output regPkg::regResp_t resp,
	output logic respValid,
	input wire respReady,
	output regPkg::wrEvent_t wrEvent
);

	regPkg::regData_t regs [regPkg::RegCount];
	logic [$clog2(regPkg::RegCount)-1:0] idx;
	logic inMap;
	logic accept;
	regPkg::regData_t readData;

	// Stall while a read result still sits in resp
	assign cmdReady = !respValid;
	assign accept = cmdValid && cmdReady;

	assign idx = cmd.addr[$clog2(regPkg::RegCount)-1:0];
	assign inMap = (int'(cmd.addr) < regPkg::RegCount);

	// Read mux
	always_comb
	begin
		if (!inMap)
			readData = regPkg::UnmappedRead;
		else if (idx == '0)
			readData = regPkg::DeviceId;
		else
			readData = regs[idx];
	end

	always_ff @(posedge iSCLK)
	begin
		if (rst)
		begin
			for (int i = 0; i < regPkg::RegCount; i++)
				regs[i] <= '0;
			respValid <= 1'b0;
			wrEvent.valid <= 1'b0;
		end
		else
		begin
			// Single-cycle event pulse
			wrEvent.valid <= 1'b0;
			if (respValid && respReady)
				respValid <= 1'b0;
			if (accept)
			begin
				if (cmd.isRead)
				begin
					resp.data <= readData;
					respValid <= 1'b1;
				end
				// ID and unmapped addresses ignore writes
				else if (inMap && idx != '0 && regs[idx] != cmd.data)
				begin
					regs[idx] <= cmd.data;
					wrEvent.valid <= 1'b1;
					wrEvent.addr <= cmd.addr;
					wrEvent.data <= cmd.data;
				end
			end
		end
	end

	// Refused command stays in place until the bank takes it
	cmdInHold: assert property (@(posedge iSCLK) disable iff (rst)
		cmdValid && !cmdReady |=> cmdValid && $stable(cmd));

endmodule

`default_nettype wire

//--- rtl/spiFrameDecoder.sv
// Frame decoder FSM shifting in command, address and data and issuing register commands
`timescale 1ns/100ps
`default_nettype none

module spiFrameDecoder (
	input wire iSCLK,
	input wire rst,
	input wire decodeDisable,
	input wire sckRise,
	input wire mosiBit,
	input wire csActive,
	input wire csStart,
	output regPkg::regCmd_t cmd,
	output logic cmdValid,
	input wire cmdReady
);

	typedef enum logic [2:0] {Idle, Command, Address, Data, Skip} decState_t;

	decState_t state;
	logic [5:0] bitCnt;
	logic [5:0] fieldLast;
	logic fieldDone;
	logic [spiPkg::DataBits-1:0] shiftReg;
	logic [spiPkg::DataBits-1:0] shiftNext;
	spiPkg::spiCmd_t opcode;
	logic isReadReg;
	regPkg::regAddr_t addrReg;

	// Shift register including the bit arriving now
	assign shiftNext = {shiftReg[spiPkg::DataBits-2:0], mosiBit};
	assign opcode = shiftNext[spiPkg::CmdBits-1:0];

	// Last bit index of the field being received
	always_comb
	begin
		case (state)
			Command: fieldLast = 6'(spiPkg::CmdBits - 1);
			Address: fieldLast = 6'(spiPkg::AddrBits - 1);
			default: fieldLast = 6'(spiPkg::DataBits - 1);
		endcase
	end

	assign fieldDone = (bitCnt == fieldLast);

	always_ff @(posedge iSCLK)
	begin
		if (rst)
		begin
			state <= Idle;
			bitCnt <= '0;
			cmdValid <= 1'b0;
		end
		else
		begin
			// Bank took the command
			if (cmdValid && cmdReady)
				cmdValid <= 1'b0;
			// CS high drops any partial frame
			if (!csActive)
			begin
				state <= Idle;
				bitCnt <= '0;
			end
			else if (csStart)
			begin
				state <= decodeDisable ? Skip : Command;
				bitCnt <= '0;
			end
			else if (decodeDisable)
				state <= Skip;
			else if (sckRise && state != Idle && state != Skip)
			begin
				shiftReg <= shiftNext;
				bitCnt <= fieldDone ? 6'd0 : bitCnt + 6'd1;
				if (fieldDone)
				begin
					case (state)
						Command:
						begin
							// Unknown opcodes wait out the frame
							if (opcode == spiPkg::CmdWrite || opcode == spiPkg::CmdRead)
							begin
								isReadReg <= (opcode == spiPkg::CmdRead);
								state <= Address;
							end
							else
								state <= Skip;
						end
						Address:
						begin
							addrReg <= shiftNext[spiPkg::AddrBits-1:0];
							// Read goes out now so data is ready for the data phase
							if (isReadReg)
							begin
								cmd.isRead <= 1'b1;
								cmd.addr <= shiftNext[spiPkg::AddrBits-1:0];
								cmd.data <= '0;
								cmdValid <= 1'b1;
								state <= Skip;
							end
							else
								state <= Data;
						end
						Data:
						begin
							cmd.isRead <= 1'b0;
							cmd.addr <= addrReg;
							cmd.data <= shiftNext;
							cmdValid <= 1'b1;
							state <= Skip;
						end
						default:
							state <= Skip;
					endcase
				end
			end
		end
	end

	// Pending command is held until the bank accepts it
	cmdHold: assert property (@(posedge iSCLK) disable iff (rst)
		cmdValid && !cmdReady |=> cmdValid && $stable(cmd));

endmodule

`default_nettype wire

//--- rtl/spiPinSync.sv
// Two-flop synchronizer for SCK, MOSI and CS with SCK edge and CS frame strobes
`timescale 1ns/100ps
`default_nettype none

module spiPinSync (
	input wire iSCLK,
	input wire rst,
	input wire spiPkg::spiPins_t pins,
	output logic sckRise,
	output logic sckFall,
	output logic mosiBit,
	output logic csActive,
	output logic csStart,
	output logic csEnd
);

	// Metastability stages and the previous synchronized sample
	spiPkg::spiPins_t syncA;
	spiPkg::spiPins_t syncB;
	spiPkg::spiPins_t prev;

	always_ff @(posedge iSCLK)
	begin
		if (rst)
		begin
			// CS idles high, SCK idles low in mode 0
			syncA <= '{sck: 1'b0, mosi: 1'b0, cs: 1'b1};
			syncB <= '{sck: 1'b0, mosi: 1'b0, cs: 1'b1};
			prev <= '{sck: 1'b0, mosi: 1'b0, cs: 1'b1};
			sckRise <= 1'b0;
			sckFall <= 1'b0;
			mosiBit <= 1'b0;
			csActive <= 1'b0;
			csStart <= 1'b0;
			csEnd <= 1'b0;
		end
		else
		begin
			syncA <= pins;
			syncB <= syncA;
			prev <= syncB;
			// Strobes registered so they line up with mosiBit
			sckRise <= syncB.sck & ~prev.sck;
			sckFall <= ~syncB.sck & prev.sck;
			mosiBit <= syncB.mosi;
			csActive <= ~syncB.cs;
			// CS falling opens a frame
			csStart <= prev.cs & ~syncB.cs;
			csEnd <= ~prev.cs & syncB.cs;
		end
	end

endmodule

`default_nettype wire

//--- rtl/regPkg.sv
// Register map typedefs, command and response structs, write event and map constants
`default_nettype none

package regPkg;

	typedef logic [15:0] regAddr_t;
	typedef logic [31:0] regData_t;

	// Decoded frame handed to the register bank
	typedef struct packed {
		logic isRead;
		regAddr_t addr;
		regData_t data;
	} regCmd_t;

	// Read data handed to the MISO shifter
	typedef struct packed {
		regData_t data;
	} regResp_t;

	// Notice of an accepted write for the FPGA fabric
	typedef struct packed {
		logic valid;
		regAddr_t addr;
		regData_t data;
	} wrEvent_t;

	localparam int RegCount = 8;
	localparam regData_t DeviceId = 32'h5350_4901;
	localparam regData_t UnmappedRead = 32'hDEAD_BEEF;

endpackage

`default_nettype wire

//--- rtl/spiPkg.sv
// SPI pin and flash bus structs, frame field lengths, command codes and flash count
`default_nettype none

package spiPkg;

	// Number of external flash ports behind the bridge
	localparam int FlashCount = 3;

	// One set of SPI wires as seen on a pin group
	typedef struct packed {
		logic sck;
		logic mosi;
		logic cs;
	} spiPins_t;

	// Same wires for all flash ports, one bit per flash
	typedef struct packed {
		logic [FlashCount-1:0] sck;
		logic [FlashCount-1:0] mosi;
		logic [FlashCount-1:0] cs;
	} flashBus_t;

	// First byte of every frame
	typedef logic [7:0] spiCmd_t;

	localparam spiCmd_t CmdWrite = 8'h02;
	localparam spiCmd_t CmdRead = 8'h03;

	// Field lengths in SCK cycles
	localparam int CmdBits = 8;
	localparam int AddrBits = 16;
	localparam int DataBits = 32;

endpackage

`default_nettype wire
